/* standby_pkg.sv */
`default_nettype none

package standby_pkg;

   // ######################################################################
   // widths and command encoding
   // ######################################################################

   localparam int data_w = 16;    // operand and accumulator width

   typedef enum logic [1:0] {
      op_add  = 2'd0,             // acc + operand
      op_xor  = 2'd1,             // acc ^ operand
      op_load = 2'd2,             // acc = operand
      op_nop  = 2'd3              // acc kept, result still reported
   } op_t;

   // 18 bits, opcode on top
   typedef struct packed {
      op_t               op;
      logic [data_w-1:0] data;
   } cmd_t;

   // ######################################################################
   // default timing values, overridden from the top level
   // ######################################################################

   localparam int pd_default         = 5;  // stay-awake cycles
   localparam int syncpipe_default   = 2;  // synchronizer stages
   localparam int delay_default      = 5;  // boot pulse delay
   localparam int fifo_depth_default = 4;  // command entries

endpackage

`default_nettype wire

/* cmd_if.sv */
`timescale 1ns/1ns
`default_nettype none

// read side of the command FIFO
interface cmd_if;

   import standby_pkg::*;

   cmd_t rdata;   // head entry
   logic empty;   // nothing queued
   logic pop;     // take head, only while empty low
   logic clr;     // flush all entries

   // buffer drives data and status
   modport fifo_side (
      output rdata,
      output empty,
      input  pop,
      input  clr
   );

   // consumer drives the strobes
   modport core_side (
      input  rdata,
      input  empty,
      output pop,
      output clr
   );

endinterface

`default_nettype wire

/* boot_pulse_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module boot_pulse_gen #(
   parameter int SYNCPIPE = standby_pkg::syncpipe_default,
   parameter int DELAY    = standby_pkg::delay_default
) (
   input  logic clkin,
   input  logic nreset,
   input  logic boot,        // reset level, async to clkin
   output logic edge_pulse,  // one cycle, right after sync
   output logic boot_pulse   // one cycle, DELAY cycles later
);

   logic [SYNCPIPE-1:0] sync_q;   // metastability chain
   logic                sync_d;   // previous synced level
   logic [DELAY-1:0]    dly_q;    // fixed delay line

   // synchronizer chain, stage 0 samples the raw level
   always_ff @(posedge clkin or negedge nreset) begin
      if (!nreset) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= boot;
         for (int i = 1; i < SYNCPIPE; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // registered rising edge detect
   always_ff @(posedge clkin or negedge nreset) begin
      if (!nreset) begin
         sync_d     <= 1'b0;
         edge_pulse <= 1'b0;
      end else begin
         sync_d     <= sync_q[SYNCPIPE-1];
         edge_pulse <= sync_q[SYNCPIPE-1] & ~sync_d;  // low to high only
      end
   end

   // shift the pulse down DELAY stages
   always_ff @(posedge clkin or negedge nreset) begin
      if (!nreset) begin
         dly_q <= '0;
      end else begin
         dly_q[0] <= edge_pulse;
         for (int i = 1; i < DELAY; i++) begin
            dly_q[i] <= dly_q[i-1];
         end
      end
   end

   assign boot_pulse = dly_q[DELAY-1];  // once per reset release

endmodule

`default_nettype wire

/* clock_gate.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gate (
   input  logic clkin,
   input  logic en,     // functional enable
   input  logic te,     // scan override
   output logic gclk
);

   logic en_lat;

   // transparent while clkin low, holds through the high phase
   always_latch begin
      if (!clkin) begin
         en_lat = en | te;
      end
   end

   // enable is stable while clkin is high, so no glitch
   assign gclk = clkin & en_lat;

endmodule

`default_nettype wire

/* standby_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module standby_ctrl #(
   parameter int PD       = standby_pkg::pd_default,
   parameter int SYNCPIPE = standby_pkg::syncpipe_default,
   parameter int DELAY    = standby_pkg::delay_default
) (
   input  logic clkin,
   input  logic nreset,
   input  logic testenable,  // static, forces clock on
   input  logic wakeup,      // level, active high
   input  logic idle,        // core has nothing to do
   output logic resetout,    // one cycle boot pulse
   output logic clkout       // gated core clock
);

   logic          edge_pulse;    // early pulse, fills the pipe
   logic          wakeup_now;
   logic [PD-1:0] wakeup_pipe;   // stay-awake history
   logic          clk_en;

   // ######################################################################
   // boot pulse from reset release
   // ######################################################################

   boot_pulse_gen #(
      .SYNCPIPE (SYNCPIPE),
      .DELAY    (DELAY)
   ) boot_pulse_gen_inst (
      .clkin      (clkin),
      .nreset     (nreset),
      .boot       (nreset),     // release of reset is the boot event
      .edge_pulse (edge_pulse),
      .boot_pulse (resetout)
   );

   // ######################################################################
   // stay awake and clock enable
   // ######################################################################

   // early pulse keeps clock up until the delayed pulse reaches the core
   assign wakeup_now = edge_pulse | wakeup;

   always_ff @(posedge clkin or negedge nreset) begin
      if (!nreset) begin
         wakeup_pipe <= '0;
      end else begin
         wakeup_pipe[0] <= wakeup_now;
         for (int i = 1; i < PD; i++) begin
            wakeup_pipe[i] <= wakeup_pipe[i-1];  // PD more cycles
         end
      end
   end

   assign clk_en = wakeup           // awake right away
                 | (|wakeup_pipe)   // recent wakeup or boot
                 | ~idle;           // core busy

   clock_gate clock_gate_inst (
      .clkin (clkin),
      .en    (clk_en),
      .te    (testenable),
      .gclk  (clkout)
   );

endmodule

`default_nettype wire

/* cmd_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo #(
   parameter int DEPTH = standby_pkg::fifo_depth_default
) (
   input  logic              clkin,
   input  logic              nreset,
   input  logic              push,    // write strobe
   input  standby_pkg::cmd_t wdata,
   output logic              full,
   cmd_if.fifo_side          rd
);

   import standby_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
   localparam int CW = $clog2(DEPTH + 1);                // count width

   cmd_t          mem [DEPTH];
   logic [AW-1:0] wptr;
   logic [AW-1:0] rptr;
   logic [CW-1:0] count;
   logic          do_push;
   logic          do_pop;

   // ######################################################################
   // flags and qualified strobes
   // ######################################################################

   assign full     = (count == CW'(DEPTH));
   assign rd.empty = (count == '0);
   assign do_push  = push & ~full;       // push at full is dropped
   assign do_pop   = rd.pop & ~rd.empty;
   assign rd.rdata = mem[rptr];          // head, shown before pop

   // ######################################################################
   // pointers and count
   // ######################################################################

   always_ff @(posedge clkin or negedge nreset) begin
      if (!nreset) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else if (rd.clr) begin       // boot flush
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;  // wrap
         end
         if (do_pop) begin
            rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // both or neither
         endcase
      end
   end

   // storage, written at the write pointer
   always_ff @(posedge clkin) begin
      if (do_push) begin
         mem[wptr] <= wdata;
      end
   end

endmodule

`default_nettype wire

/* gated_core.sv */
`timescale 1ns/1ns
`default_nettype none

module gated_core (
   input  logic                            clkout,   // gated clock
   input  logic                            nreset,
   input  logic                            boot,     // one cycle clear
   cmd_if.core_side                        rd,
   output logic                            idle,
   output logic [standby_pkg::data_w-1:0]  result,
   output logic                            result_valid
);

   import standby_pkg::*;

   cmd_t              stage_cmd;    // popped command
   logic              stage_valid;
   logic [data_w-1:0] acc;
   logic [data_w-1:0] acc_next;

   // ######################################################################
   // read side strobes
   // ######################################################################

   assign rd.pop = ~rd.empty & ~boot;   // no pop while flushing
   assign rd.clr = boot;                // boot also empties the FIFO

   // busy while anything is queued, staged or being reported
   assign idle = rd.empty & ~stage_valid & ~result_valid;

   // ######################################################################
   // execute
   // ######################################################################

   always_comb begin
      case (stage_cmd.op)
         op_add:  acc_next = acc + stage_cmd.data;
         op_xor:  acc_next = acc ^ stage_cmd.data;
         op_load: acc_next = stage_cmd.data;
         default: acc_next = acc;               // nop
      endcase
   end

   always_ff @(posedge clkout or negedge nreset) begin
      if (!nreset) begin
         stage_valid  <= 1'b0;
         acc          <= '0;
         result_valid <= 1'b0;
      end else if (boot) begin
         stage_valid  <= 1'b0;
         acc          <= '0;
         result_valid <= 1'b0;
      end else begin
         stage_valid  <= rd.pop;        // one pop per edge
         result_valid <= stage_valid;   // one cycle pulse
         if (stage_valid) begin
            acc <= acc_next;
         end
      end
   end

   // payload stage, follows the valid bit
   always_ff @(posedge clkout) begin
      if (rd.pop) begin
         stage_cmd <= rd.rdata;
      end
   end

   assign result = acc;  // valid with result_valid

endmodule

`default_nettype wire

/* standby_top.sv */
`timescale 1ns/1ns
`default_nettype none

module standby_top #(
   parameter int PD       = standby_pkg::pd_default,
   parameter int SYNCPIPE = standby_pkg::syncpipe_default,
   parameter int DELAY    = standby_pkg::delay_default,
   parameter int DEPTH    = standby_pkg::fifo_depth_default
) (
   input  logic                            clkin,
   input  logic                            nreset,
   input  logic                            testenable,
   input  logic                            wakeup,
   input  logic                            push,
   input  standby_pkg::op_t                op,
   input  logic [standby_pkg::data_w-1:0]  operand,
   output logic                            full,
   output logic [standby_pkg::data_w-1:0]  result,
   output logic                            result_valid,
   output logic                            resetout,
   output logic                            clkout
);

   import standby_pkg::*;

   cmd_t wdata;  // ports packed into one command
   logic idle;

   cmd_if cmd_bus ();

   assign wdata = '{op: op, data: operand};

   standby_ctrl #(
      .PD       (PD),
      .SYNCPIPE (SYNCPIPE),
      .DELAY    (DELAY)
   ) standby_ctrl_inst (
      .clkin      (clkin),
      .nreset     (nreset),
      .testenable (testenable),
      .wakeup     (wakeup),
      .idle       (idle),
      .resetout   (resetout),
      .clkout     (clkout)
   );

   // free running side
   cmd_fifo #(
      .DEPTH (DEPTH)
   ) cmd_fifo_inst (
      .clkin  (clkin),
      .nreset (nreset),
      .push   (push),
      .wdata  (wdata),
      .full   (full),
      .rd     (cmd_bus.fifo_side)
   );

   // gated side
   gated_core gated_core_inst (
      .clkout       (clkout),
      .nreset       (nreset),
      .boot         (resetout),
      .rd           (cmd_bus.core_side),
      .idle         (idle),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

`default_nettype wire

/* standby_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module standby_sva (
   input logic clk,          // clock of the bound module
   input logic nreset,
   input logic resetout,     // boot pulse as seen there
   input logic pop,
   input logic empty,
   input logic gclk,         // gated clock output
   input logic testenable
);

   int err_cnt = 0;          // failed assertion count

   // boot pulse lasts one cycle only
   boot_single : assert property (@(posedge clk) disable iff (!nreset)
      resetout |=> !resetout)
      else begin
         $error("resetout high on two consecutive cycles");
         err_cnt++;
      end

   // core pops only a non-empty FIFO
   pop_not_empty : assert property (@(posedge clk) disable iff (!nreset)
      pop |-> !empty)
      else begin
         $error("pop asserted while the FIFO is empty");
         err_cnt++;
      end

   // sampled just before the falling edge, so within the high phase
   te_clock_on : assert property (@(negedge clk) disable iff (!nreset)
      (testenable && $past(testenable)) |-> gclk)
      else begin
         $error("gated clock low in a high phase with testenable set");
         err_cnt++;
      end

endmodule

// ######################################################################
// attach to the controller and to the core
// ######################################################################

bind standby_ctrl standby_sva ctrl_sva (
   .clk (clkin), .nreset (nreset), .resetout (resetout), .pop (1'b0),
   .empty (1'b0), .gclk (clkout), .testenable (testenable)
);

bind gated_core standby_sva core_sva (
   .clk (clkout), .nreset (nreset), .resetout (boot), .pop (rd.pop),
   .empty (rd.empty), .gclk (1'b0), .testenable (1'b0)
);

`default_nettype wire

/* tb_standby.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_standby;

   import standby_pkg::*;

   typedef struct packed {
      logic [7:0]        id;
      op_t               op;
      logic [data_w-1:0] data;
      logic              te;    // testenable during the row
      logic              wk;    // wakeup during the row
   } row_t;

   localparam int n_rows     = 8;
   localparam int max_cycles = 40 * n_rows + 200;                  // watchdog limit
   localparam int boot_limit = syncpipe_default + delay_default + 3;
   localparam int awake_chk  = pd_default + 5;                     // cycles held awake

   logic              clkin = 1'b0;
   logic              nreset, testenable, wakeup, push;
   op_t               op;
   logic [data_w-1:0] operand, result;
   logic              full, result_valid, resetout, clkout;

   row_t              stim [n_rows];
   logic [data_w-1:0] results_q [$];   // seen on result_valid
   logic [data_w-1:0] exp_q [$];       // predicted by the model
   logic [data_w-1:0] model_acc = '0;
   int fifo_lvl = 0;                   // predicted FIFO occupancy
   int cycle_cnt = 0, gclk_cnt = 0, boot_cnt = 0, boot_cycle = 0;
   int err_cnt = 0, err_mark = 0, pass_cnt = 0, fail_cnt = 0, dropped = 0;

   standby_top standby_top_inst (
      .clkin (clkin), .nreset (nreset), .testenable (testenable), .wakeup (wakeup),
      .push (push), .op (op), .operand (operand), .full (full), .result (result),
      .result_valid (result_valid), .resetout (resetout), .clkout (clkout)
   );

   always #50 clkin = ~clkin;  // 100 ns period

   // ######################################################################
   // monitor and watchdog, sampled mid high phase
   // ######################################################################

   always @(posedge clkin) begin
      #25;
      cycle_cnt++;
      if (result_valid) results_q.push_back(result);
      if (clkout) gclk_cnt++;           // gated edge this cycle
      if (resetout) begin
         boot_cnt++;
         if (boot_cnt == 1) boot_cycle = cycle_cnt;
      end
   end

   initial begin
      wait (cycle_cnt >= max_cycles);
      $display("run timed out after %0d clkin cycles", cycle_cnt);
      $display("Something failed");
      $finish;
   end

   // ######################################################################
   // helpers
   // ######################################################################

   task automatic step();
      @(posedge clkin);
      #5;                               // drive point
   endtask

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      if (got !== exp) begin
         $display("FAIL %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
         err_cnt++;
      end
   endtask

   // accumulator rules per opcode
   function automatic logic [data_w-1:0] apply_op(input logic [data_w-1:0] acc,
                                                  input op_t cmd_op,
                                                  input logic [data_w-1:0] val);
      case (cmd_op)
         op_add:  return acc + val;
         op_xor:  return acc ^ val;
         op_load: return val;
         default: return acc;
      endcase
   endfunction

   task automatic push_cmd(input op_t cmd_op, input logic [data_w-1:0] val);
      logic exp_full;
      exp_full = (fifo_lvl == fifo_depth_default);
      push     = 1'b1;
      op       = cmd_op;
      operand  = val;
      #15;
      check_equal(full, exp_full, "full at push");
      if (!exp_full) begin              // written at the coming edge
         model_acc = apply_op(model_acc, cmd_op, val);
         exp_q.push_back(model_acc);
      end else begin
         dropped++;
      end
      // core takes the head on the same edge whenever one is queued
      fifo_lvl = fifo_lvl + (exp_full ? 0 : 1) - ((fifo_lvl > 0) ? 1 : 0);
      step();
      push = 1'b0;
   endtask

   task automatic drain_results(input string what);
      while (results_q.size() < exp_q.size()) step();
      repeat (2) step();                // catch stray pulses
      check_equal(results_q.size(), exp_q.size(), {what, " result count"});
      while (exp_q.size() > 0 && results_q.size() > 0) begin
         check_equal(results_q.pop_front(), exp_q.pop_front(), {what, " result"});
      end
      results_q.delete();
      exp_q.delete();
      fifo_lvl = 0;                     // all queued commands consumed
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_mark) begin
         pass_cnt++;
         $display("%s: pass", name);
      end else begin
         fail_cnt++;
         $display("%s: failed with %0d mismatches", name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   // ######################################################################
   // stimulus
   // ######################################################################

   initial begin
      int g0;
      int sva_errs;
      void'($urandom(49192));
      nreset     = 1'b0;
      testenable = 1'b0;
      wakeup     = 1'b0;
      push       = 1'b0;
      op         = op_nop;
      operand    = '0;
      stim = '{                         // id, op, operand, te, wakeup
         '{8'd1, op_load, 16'h1234, 1'b0, 1'b0},
         '{8'd2, op_add,  16'hf0f0, 1'b0, 1'b0},
         '{8'd3, op_xor,  16'hffff, 1'b0, 1'b1},
         '{8'd4, op_nop,  16'h0bad, 1'b0, 1'b0},
         '{8'd5, op_add,  16'h8000, 1'b1, 1'b0},
         '{8'd6, op_load, 16'ha5a5, 1'b0, 1'b0},
         '{8'd7, op_xor,  16'h5a5a, 1'b0, 1'b1},
         '{8'd8, op_add,  16'h0001, 1'b1, 1'b0}
      };

      repeat (3) step();                // reset for 3 cycles
      nreset = 1'b1;
      g0 = cycle_cnt;
      repeat (20) step();
      check_equal(boot_cnt, 1, "resetout pulse count");
      check_equal((boot_cycle - g0) <= boot_limit, 1, "resetout latency");
      check_equal(result, 0, "result after boot");
      end_test("boot pulse");

      for (int r = 0; r < n_rows; r++) begin
         testenable = stim[r].te;
         wakeup     = stim[r].wk;
         push_cmd(stim[r].op, stim[r].data);
         drain_results($sformatf("row %0d", stim[r].id));
         if (stim[r].te || stim[r].wk) begin  // idle core, clock forced
            g0 = gclk_cnt;
            repeat (awake_chk) step();
            check_equal(gclk_cnt - g0, awake_chk, "clkout toggling while held awake");
         end
         end_test($sformatf("row %0d", stim[r].id));
         repeat ($urandom_range(0, 3)) step();
      end

      testenable = 1'b0;
      wakeup     = 1'b1;                // keep the core clocked
      for (int i = 0; i < fifo_depth_default + 3; i++) begin
         push_cmd(op_t'(2'(i)), 16'($urandom));
      end
      drain_results("back-pressure");
      end_test($sformatf("back-pressure, %0d pushes dropped", dropped));

      wakeup = 1'b0;
      repeat (pd_default + 4) step();   // stay-awake pipe runs out
      g0 = gclk_cnt;
      repeat (20) step();
      check_equal(gclk_cnt - g0, 0, "clkout stopped while idle");
      push_cmd(op_add, 16'h0101);       // must wake the core
      drain_results("after clock stop");
      end_test("clock stop");

      sva_errs = standby_top_inst.standby_ctrl_inst.ctrl_sva.err_cnt
               + standby_top_inst.gated_core_inst.core_sva.err_cnt;
      $display("tests passed %0d, failed %0d, assertion failures %0d",
               pass_cnt, fail_cnt, sva_errs);
      if (err_cnt == 0 && fail_cnt == 0 && sva_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
standby_pkg.sv
cmd_if.sv
boot_pulse_gen.sv
clock_gate.sv
standby_ctrl.sv
cmd_fifo.sv
gated_core.sv
standby_top.sv
standby_sva.sv
tb_standby.sv

/* Bender.yml */
package:
  name: standby

sources:
  - standby_pkg.sv
  - cmd_if.sv
  - boot_pulse_gen.sv
  - clock_gate.sv
  - standby_ctrl.sv
  - cmd_fifo.sv
  - gated_core.sv
  - standby_top.sv
  - target: test
    files:
      - standby_sva.sv
      - tb_standby.sv
